/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // RV32I major opcodes.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_ALU    = 7'b0110011;
  localparam logic [6:0] OP_ALUI   = 7'b0010011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    SLT   = 4'd8,
    SLTU  = 4'd9,
    SGE   = 4'd10,
    SGEU  = 4'd11,
    PASSB = 4'd12
  } alu_op_e;

  // Same values as funct3 of the SYSTEM opcode.
  typedef enum logic [3:0] {
    PRIV   = 4'd0,
    CSRRW  = 4'd1,
    CSRRS  = 4'd2,
    CSRRC  = 4'd3,
    CSRRWI = 4'd5,
    CSRRSI = 4'd6,
    CSRRCI = 4'd7
  } sys_func_e;

  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;
  localparam logic [11:0] PRIV_MRET   = 12'h302;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [31:0] CAUSE_ECALL_M = 32'd11; // Environment call from M-mode.

endpackage

/* hw/exu_mem_pkg.sv */
package exu_mem_pkg;

  typedef enum logic [1:0] {
    NONE  = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2
  } lsu_op_e;

  // Longest wait for a bus acknowledge, in clock cycles.
  localparam logic [31:0] LSU_MAX_WAIT = 32'd16;

endpackage

/* hw/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]   alu_a_i,
  input  logic [XLEN-1:0]   alu_b_i,
  input  rv_isa_pkg::alu_op_e alu_op_i,
  output logic [XLEN-1:0]   alu_res_o
);
  import rv_isa_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  assign shamt = alu_b_i[SHW-1:0];
  assign lt_s  = $signed(alu_a_i) < $signed(alu_b_i);
  assign lt_u  = alu_a_i < alu_b_i;

  always_comb begin
    case (alu_op_i)
      ADD:     alu_res_o = alu_a_i + alu_b_i;
      SUB:     alu_res_o = alu_a_i - alu_b_i;
      AND:     alu_res_o = alu_a_i & alu_b_i;
      OR:      alu_res_o = alu_a_i | alu_b_i;
      XOR:     alu_res_o = alu_a_i ^ alu_b_i;
      SLL:     alu_res_o = alu_a_i << shamt;
      SRL:     alu_res_o = alu_a_i >> shamt;
      SRA:     alu_res_o = $unsigned($signed(alu_a_i) >>> shamt);
      SLT:     alu_res_o = {{(XLEN-1){1'b0}}, lt_s};
      SLTU:    alu_res_o = {{(XLEN-1){1'b0}}, lt_u};
      SGE:     alu_res_o = {{(XLEN-1){1'b0}}, ~lt_s};
      SGEU:    alu_res_o = {{(XLEN-1){1'b0}}, ~lt_u};
      PASSB:   alu_res_o = alu_b_i; // LUI result.
      default: alu_res_o = '0;
    endcase
  end

endmodule

/* hw/exu_csr_file.sv */
`timescale 1ns/1ps

module exu_csr_file #(
  parameter int              XLEN        = 32,
  parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [11:0]     csr_addr_i,
  input  logic            csr_we_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            trap_ecall_i,
  input  logic            trap_mret_i,
  input  logic [XLEN-1:0] epc_i,
  output logic [XLEN-1:0] csr_rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);
  import rv_isa_pkg::*;

  localparam int MIE  = 3;
  localparam int MPIE = 7;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (trap_ecall_i) begin
      mepc_q          <= epc_i;
      mcause_q        <= XLEN'(CAUSE_ECALL_M);
      mstatus_q[MPIE] <= mstatus_q[MIE]; // Stack the interrupt enable.
      mstatus_q[MIE]  <= 1'b0;
    end else if (trap_mret_i) begin
      mstatus_q[MIE]  <= mstatus_q[MPIE];
      mstatus_q[MPIE] <= 1'b1;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: mstatus_q <= csr_wdata_i;
        CSR_MTVEC:   mtvec_q   <= csr_wdata_i;
        CSR_MEPC:    mepc_q    <= csr_wdata_i;
        CSR_MCAUSE:  mcause_q  <= csr_wdata_i;
        default:     ;
      endcase
    end
  end

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o = mstatus_q;
      CSR_MTVEC:   csr_rdata_o = mtvec_q;
      CSR_MEPC:    csr_rdata_o = mepc_q;
      CSR_MCAUSE:  csr_rdata_o = mcause_q;
      default:     csr_rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  a_trap_excl: assert property (@(posedge clk) disable iff (rst)
    !(trap_ecall_i && trap_mret_i))
    else $error("ecall and mret strobes coincide");

endmodule

/* hw/exu_lsu_wb.sv */
`timescale 1ns/1ps

module exu_lsu_wb #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lsu_req_i,
  input  exu_mem_pkg::lsu_op_e lsu_op_i,
  input  logic [XLEN-1:0]      lsu_addr_i,
  input  logic [XLEN-1:0]      lsu_wdata_i,
  output logic                 lsu_done_o,
  output logic [XLEN-1:0]      lsu_rdata_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output logic [XLEN-1:0]      wb_adr_o,
  output logic [XLEN-1:0]      wb_dat_o,
  output logic [XLEN/8-1:0]    wb_sel_o,
  input  logic [XLEN-1:0]      wb_dat_i,
  input  logic                 wb_ack_i
);
  import exu_mem_pkg::*;

  typedef enum logic {L_IDLE, L_BUS} lsu_state_e;

  lsu_state_e state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= L_IDLE;
      lsu_done_o <= 1'b0;
    end else begin
      lsu_done_o <= 1'b0;
      case (state_q)
        L_IDLE: if (lsu_req_i && lsu_op_i != NONE) state_q <= L_BUS;
        L_BUS: begin
          if (wb_ack_i) begin
            state_q    <= L_IDLE;
            lsu_done_o <= 1'b1; // Pulse in the cycle after the ack edge.
          end
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == L_IDLE && lsu_req_i) begin
      wb_adr_o <= lsu_addr_i;
      wb_dat_o <= lsu_wdata_i;
      wb_we_o  <= lsu_op_i == STORE;
    end
    if (state_q == L_BUS && wb_ack_i) lsu_rdata_o <= wb_dat_i;
  end

  assign wb_cyc_o = state_q == L_BUS;
  assign wb_stb_o = state_q == L_BUS;
  assign wb_sel_o = '1; // Word accesses only.

  a_cyc_drop: assert property (@(posedge clk) disable iff (rst)
    wb_cyc_o && wb_ack_i |=> !wb_cyc_o && !wb_stb_o)
    else $error("wb_cyc_o or wb_stb_o still high in the cycle after ack");

  a_stable: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o)
      && $stable(wb_we_o))
    else $error("bus request changed before ack");

  a_ack_wait: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_stb_o) |-> ##[0:LSU_MAX_WAIT] wb_ack_i)
    else $error("no ack within %0d cycles", LSU_MAX_WAIT);

endmodule

/* hw/exu_core.sv */
`timescale 1ns/1ps

module exu_core #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [6:0]           opcode_i,
  input  rv_isa_pkg::alu_op_e  alu_op_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [XLEN-1:0]      rs1_val_i,
  input  logic [XLEN-1:0]      rs2_val_i,
  input  logic [4:0]           rd_i,
  input  logic                 rd_wen_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [4:0]           rd_o,
  output logic [XLEN-1:0]      rd_wdata_o,
  output logic                 rd_wen_o,
  output logic [XLEN-1:0]      npc_o,
  output logic                 ebreak_o,
  output logic [XLEN-1:0]      alu_a_o,
  output logic [XLEN-1:0]      alu_b_o,
  output rv_isa_pkg::alu_op_e  alu_op_o,
  input  logic [XLEN-1:0]      alu_res_i,
  output logic [11:0]          csr_addr_o,
  output logic                 csr_we_o,
  output logic [XLEN-1:0]      csr_wdata_o,
  output logic                 trap_ecall_o,
  output logic                 trap_mret_o,
  output logic [XLEN-1:0]      epc_o,
  input  logic [XLEN-1:0]      csr_rdata_i,
  input  logic [XLEN-1:0]      mtvec_i,
  input  logic [XLEN-1:0]      mepc_i,
  output logic                 lsu_req_o,
  output exu_mem_pkg::lsu_op_e lsu_op_o,
  output logic [XLEN-1:0]      lsu_addr_o,
  output logic [XLEN-1:0]      lsu_wdata_o,
  input  logic                 lsu_done_i,
  input  logic [XLEN-1:0]      lsu_rdata_i
);
  import rv_isa_pkg::*;
  import exu_mem_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_DONE} state_e;

  state_e          state_q;
  logic [6:0]      opcode_q;
  alu_op_e         alu_op_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;
  logic [XLEN-1:0] load_q;
  logic [4:0]      rd_q;
  logic            rd_wen_q;
  sys_func_e       func;
  logic [11:0]     sys_code;
  logic            is_mem, is_jump, is_sys, is_csr;
  logic            is_ecall, is_mret, is_ebreak;
  logic            taken, retire;
  logic [XLEN-1:0] zimm, csr_src, base, target, pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (in_valid_i)
            state_q <= (opcode_i == OP_LOAD || opcode_i == OP_STORE) ? S_EXEC : S_DONE;
        end
        S_EXEC:  state_q <= S_MEM; // Request goes out in this cycle.
        S_MEM:   if (lsu_done_i) state_q <= S_DONE;
        S_DONE:  if (out_ready_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      rs1_q    <= rs1_val_i;
      rs2_q    <= rs2_val_i;
      rd_q     <= rd_i;
      rd_wen_q <= rd_wen_i;
    end
    if (state_q == S_MEM && lsu_done_i) load_q <= lsu_rdata_i;
  end

  assign in_ready_o  = state_q == S_IDLE;
  assign out_valid_o = state_q == S_DONE;
  assign retire      = out_valid_o && out_ready_i;

  // SYSTEM fields packed in the immediate.
  assign func      = sys_func_e'(imm_q[3:0]);
  assign sys_code  = imm_q[15:4];
  assign zimm      = {{(XLEN-5){1'b0}}, imm_q[20:16]};
  assign is_mem    = opcode_q == OP_LOAD || opcode_q == OP_STORE;
  assign is_jump   = opcode_q == OP_JAL || opcode_q == OP_JALR;
  assign is_sys    = opcode_q == OP_SYSTEM;
  assign is_csr    = is_sys && func != PRIV;
  assign is_ecall  = is_sys && func == PRIV && sys_code == PRIV_ECALL;
  assign is_mret   = is_sys && func == PRIV && sys_code == PRIV_MRET;
  assign is_ebreak = is_sys && func == PRIV && sys_code == PRIV_EBREAK;

  assign alu_a_o  = (opcode_q inside {OP_AUIPC, OP_JAL, OP_JALR}) ? pc_q : rs1_q;
  assign alu_b_o  = (opcode_q inside {OP_ALU, OP_BRANCH}) ? rs2_q : imm_q;
  assign alu_op_o = alu_op_q;

  assign base     = (opcode_q == OP_JALR || is_mem) ? rs1_q : pc_q;
  assign target   = base + imm_q;
  assign pc_plus4 = pc_q + XLEN'(4);
  assign taken    = (alu_op_q == SUB) ? (alu_res_i == '0) : (alu_res_i != '0);

  always_comb begin
    npc_o = pc_plus4;
    if (opcode_q == OP_BRANCH && taken) npc_o = target;
    else if (is_jump) npc_o = {target[XLEN-1:1], 1'b0};
    else if (is_ecall) npc_o = mtvec_i;
    else if (is_mret) npc_o = mepc_i;
  end

  assign csr_src = func[2] ? zimm : rs1_q; // Immediate forms have funct3 bit 2 set.

  always_comb begin
    case (func)
      CSRRW, CSRRWI: csr_wdata_o = csr_src;
      CSRRS, CSRRSI: csr_wdata_o = csr_rdata_i | csr_src;
      CSRRC, CSRRCI: csr_wdata_o = csr_rdata_i & ~csr_src;
      default:       csr_wdata_o = csr_rdata_i;
    endcase
  end

  always_comb begin
    if (is_jump) rd_wdata_o = pc_plus4;
    else if (opcode_q == OP_LOAD) rd_wdata_o = load_q;
    else if (is_sys) rd_wdata_o = csr_rdata_i; // Old CSR value.
    else rd_wdata_o = alu_res_i;
  end

  // Side effects land on the retire edge only.
  assign csr_addr_o   = sys_code;
  assign csr_we_o     = retire && is_csr;
  assign trap_ecall_o = retire && is_ecall;
  assign trap_mret_o  = retire && is_mret;
  assign epc_o        = pc_q;

  assign lsu_req_o   = state_q == S_EXEC;
  assign lsu_op_o    = (opcode_q == OP_LOAD) ? LOAD : (opcode_q == OP_STORE) ? STORE : NONE;
  assign lsu_addr_o  = target;
  assign lsu_wdata_o = rs2_q;

  assign rd_o     = rd_q;
  assign rd_wen_o = rd_wen_q;
  assign ebreak_o = out_valid_o && is_ebreak;

  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rd_wdata_o) && $stable(npc_o)
      && $stable(rd_o) && $stable(rd_wen_o))
    else $error("result changed under back-pressure");

endmodule

/* hw/exu_top.sv */
`timescale 1ns/1ps

module exu_top #(
  parameter int              XLEN        = 32,
  parameter logic [XLEN-1:0] MTVEC_RESET = XLEN'('h100)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [6:0]          opcode_i,
  input  rv_isa_pkg::alu_op_e alu_op_i,
  input  logic [XLEN-1:0]     imm_i,
  input  logic [XLEN-1:0]     pc_i,
  input  logic [XLEN-1:0]     rs1_val_i,
  input  logic [XLEN-1:0]     rs2_val_i,
  input  logic [4:0]          rd_i,
  input  logic                rd_wen_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [4:0]          rd_o,
  output logic [XLEN-1:0]     rd_wdata_o,
  output logic                rd_wen_o,
  output logic [XLEN-1:0]     npc_o,
  output logic                ebreak_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [XLEN-1:0]     wb_adr_o,
  output logic [XLEN-1:0]     wb_dat_o,
  output logic [XLEN/8-1:0]   wb_sel_o,
  input  logic [XLEN-1:0]     wb_dat_i,
  input  logic                wb_ack_i
);
  import rv_isa_pkg::*;
  import exu_mem_pkg::*;

  logic [XLEN-1:0] alu_a, alu_b, alu_res;
  alu_op_e         alu_op;
  logic [11:0]     csr_addr;
  logic            csr_we, trap_ecall, trap_mret;
  logic [XLEN-1:0] csr_wdata, epc, csr_rdata, mtvec, mepc;
  logic            lsu_req, lsu_done;
  lsu_op_e         lsu_op;
  logic [XLEN-1:0] lsu_addr, lsu_wdata, lsu_rdata;

  exu_core #(.XLEN(XLEN)) u_core (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .opcode_i(opcode_i),
    .alu_op_i(alu_op_i), .imm_i(imm_i), .pc_i(pc_i),
    .rs1_val_i(rs1_val_i), .rs2_val_i(rs2_val_i), .rd_i(rd_i), .rd_wen_i(rd_wen_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .rd_o(rd_o),
    .rd_wdata_o(rd_wdata_o), .rd_wen_o(rd_wen_o), .npc_o(npc_o), .ebreak_o(ebreak_o),
    .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op), .alu_res_i(alu_res),
    .csr_addr_o(csr_addr), .csr_we_o(csr_we), .csr_wdata_o(csr_wdata),
    .trap_ecall_o(trap_ecall), .trap_mret_o(trap_mret), .epc_o(epc),
    .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc),
    .lsu_req_o(lsu_req), .lsu_op_o(lsu_op), .lsu_addr_o(lsu_addr),
    .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata)
  );

  exu_alu #(.XLEN(XLEN)) u_alu (
    .alu_a_i(alu_a), .alu_b_i(alu_b), .alu_op_i(alu_op), .alu_res_o(alu_res)
  );

  exu_csr_file #(.XLEN(XLEN), .MTVEC_RESET(MTVEC_RESET)) u_csr (
    .clk(clk), .rst(rst),
    .csr_addr_i(csr_addr), .csr_we_i(csr_we), .csr_wdata_i(csr_wdata),
    .trap_ecall_i(trap_ecall), .trap_mret_i(trap_mret), .epc_i(epc),
    .csr_rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_lsu_wb #(.XLEN(XLEN)) u_lsu (
    .clk(clk), .rst(rst),
    .lsu_req_i(lsu_req), .lsu_op_i(lsu_op), .lsu_addr_i(lsu_addr),
    .lsu_wdata_i(lsu_wdata), .lsu_done_o(lsu_done), .lsu_rdata_o(lsu_rdata),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 20ns,
  parameter int      RST_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0; // Released on a rising edge.
  end

endmodule

/* dv/tb_wb_mem.sv */
`timescale 1ns/1ps

module tb_wb_mem #(
  parameter int XLEN  = 32,
  parameter int WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [XLEN-1:0] wb_adr_i,
  input  logic [XLEN-1:0] wb_dat_i,
  output logic [XLEN-1:0] wb_dat_o,
  output logic            wb_ack_o
);

  logic [XLEN-1:0] mem [WORDS];
  logic [1:0]      delay;
  integer          seed;

  initial begin
    seed = 32'h786ce2de;
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
    for (int i = 0; i < WORDS; i++) mem[i] = (i * 32'h01010101) ^ 32'hc3a50000;
  end

  always @(posedge clk) begin
    if (rst) begin
      wb_ack_o <= 1'b0;
      delay    <= '0;
    end else if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
      if (delay == 0) begin
        wb_ack_o <= 1'b1;
        if (wb_we_i) mem[wb_adr_i[9:2]] <= wb_dat_i;
        else wb_dat_o <= mem[wb_adr_i[9:2]];
      end else begin
        delay <= delay - 1'b1;
      end
    end else begin
      wb_ack_o <= 1'b0;
      delay    <= $unsigned($random(seed)) % 4; // Wait states for the next access.
    end
  end

endmodule

/* dv/tb_exu_top.sv */
`timescale 1ns/1ps

module tb_exu_top;
  import rv_isa_pkg::*;
  import exu_mem_pkg::*;

  localparam int N_INSTR = 300;

  logic clk, rst;
  logic in_valid_i, out_ready_i, rd_wen_i, wb_ack_i;
  logic [6:0] opcode_i;
  alu_op_e alu_op_i;
  logic [31:0] imm_i, pc_i, rs1_val_i, rs2_val_i, wb_dat_i;
  logic [4:0] rd_i;
  logic in_ready_o, out_valid_o, rd_wen_o, ebreak_o, wb_cyc_o, wb_stb_o, wb_we_o;
  logic [4:0] rd_o;
  logic [31:0] rd_wdata_o, npc_o, wb_adr_o, wb_dat_o;
  logic [3:0] wb_sel_o;
  logic [31:0] exp_wdata, exp_npc, exp_addr;
  logic [4:0] exp_rd;
  logic exp_ebreak, hold_ready;
  logic exp_wen, exp_we;
  logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;
  integer seed, errors, n_tests, n_instr;

  tb_clk_gen u_clk (.clk(clk), .rst(rst));

  exu_top #(.XLEN(32), .MTVEC_RESET(32'h100)) dut (
    .clk(clk), .rst(rst), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .opcode_i(opcode_i), .alu_op_i(alu_op_i), .imm_i(imm_i), .pc_i(pc_i),
    .rs1_val_i(rs1_val_i), .rs2_val_i(rs2_val_i), .rd_i(rd_i), .rd_wen_i(rd_wen_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .rd_o(rd_o),
    .rd_wdata_o(rd_wdata_o), .rd_wen_o(rd_wen_o), .npc_o(npc_o), .ebreak_o(ebreak_o),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

  tb_wb_mem u_mem (
    .clk(clk), .rst(rst), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_we_i(wb_we_o),
    .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o), .wb_dat_o(wb_dat_i), .wb_ack_o(wb_ack_i)
  );

  a_wdata: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> rd_wdata_o == exp_wdata)
    else begin
      errors++;
      $display("Error: rd_wdata_o = %h, expected %h", $sampled(rd_wdata_o),
               $sampled(exp_wdata));
    end
  a_npc: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> npc_o == exp_npc)
    else begin
      errors++;
      $display("Error: npc_o = %h, expected %h", $sampled(npc_o), $sampled(exp_npc));
    end
  a_rd: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> rd_o == exp_rd)
    else begin
      errors++;
      $display("Error: rd_o = %h, expected %h", $sampled(rd_o), $sampled(exp_rd));
    end
  a_wen: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> rd_wen_o == exp_wen)
    else begin
      errors++;
      $display("Error: rd_wen_o = %h, expected %h", $sampled(rd_wen_o), $sampled(exp_wen));
    end
  a_ebreak: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> ebreak_o == exp_ebreak)
    else begin
      errors++;
      $display("Error: ebreak_o = %h, expected %h", $sampled(ebreak_o),
               $sampled(exp_ebreak));
    end
  a_bus: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_stb_o) |-> wb_cyc_o && wb_adr_o == exp_addr && wb_sel_o == 4'hf)
    else begin
      errors++;
      $display("Error: wb_adr_o = %h, expected %h", $sampled(wb_adr_o), $sampled(exp_addr));
    end
  a_we: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_stb_o) |-> wb_we_o == exp_we)
    else begin
      errors++;
      $display("Error: wb_we_o = %h, expected %h", $sampled(wb_we_o), $sampled(exp_we));
    end
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && !in_ready_o && $stable(rd_wdata_o)
      && $stable(npc_o) && $stable(ebreak_o))
    else begin
      errors++;
      $display("result outputs moved or in_ready_o rose while out_ready_i was low");
    end

  // Random back-pressure on the result port.
  always @(posedge clk) out_ready_i <= hold_ready ? 1'b0 : ($unsigned($random(seed)) % 4 != 0);

  initial begin
    #(N_INSTR * (LSU_MAX_WAIT + 4) * 20ns);
    $display("timeout after %0d instructions", n_instr);
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ADD:   return a + b;
      SUB:   return a - b;
      AND:   return a & b;
      OR:    return a | b;
      XOR:   return a ^ b;
      SLL:   return a << b[4:0];
      SRL:   return a >> b[4:0];
      SRA:   return $signed(a) >>> b[4:0];
      SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
      SLTU:  return (a < b) ? 1 : 0;
      SGE:   return ($signed(a) >= $signed(b)) ? 1 : 0;
      SGEU:  return (a >= b) ? 1 : 0;
      default: return b;
    endcase
  endfunction

  // BEQ, BNE, BLT, BGE, BLTU and BGEU by their compare operation.
  function automatic logic branch_taken(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      SUB:     return a == b;
      XOR:     return a != b;
      SLT:     return $signed(a) < $signed(b);
      SGE:     return $signed(a) >= $signed(b);
      SLTU:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] sys_imm(logic [3:0] fn, logic [11:0] code, logic [4:0] z);
    return {11'd0, z, code, fn};
  endfunction

  function automatic logic [31:0] csr_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return m_mstatus;
      CSR_MTVEC:   return m_mtvec;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      default:     return 32'd0;
    endcase
  endfunction

  task automatic csr_write(logic [11:0] addr, logic [31:0] val);
    case (addr)
      CSR_MSTATUS: m_mstatus = val;
      CSR_MTVEC:   m_mtvec = val;
      CSR_MEPC:    m_mepc = val;
      CSR_MCAUSE:  m_mcause = val;
      default:     ;
    endcase
  endtask

  // Called on a rising edge; returns on the retire edge.
  task automatic issue(logic [6:0] opc, alu_op_e op, logic [31:0] imm, pc, a, b,
                       logic [31:0] e_wdata, e_npc, logic e_ebk, logic [31:0] e_addr);
    logic [4:0] rd;
    logic       wen;
    rd = $random(seed);
    wen = $random(seed);
    opcode_i <= opc;
    alu_op_i <= op;
    imm_i <= imm;
    pc_i <= pc;
    rs1_val_i <= a;
    rs2_val_i <= b;
    rd_i <= rd;
    rd_wen_i <= wen;
    in_valid_i <= 1'b1;
    exp_wdata <= e_wdata;
    exp_npc <= e_npc;
    exp_ebreak <= e_ebk;
    exp_addr <= e_addr;
    exp_rd <= rd;
    exp_wen <= wen;
    exp_we <= opc == OP_STORE;
    @(posedge clk);
    in_valid_i <= 1'b0;
    do @(negedge clk); while (!(out_valid_o && out_ready_i));
    @(posedge clk);
    n_instr++;
  endtask

  task automatic csr_op(logic [3:0] fn, logic [11:0] addr, logic [31:0] src, logic [31:0] pc);
    logic [31:0] old, s, nv;
    old = csr_read(addr);
    s = fn[2] ? {27'd0, src[4:0]} : src;
    case (fn[1:0])
      2'd1:    nv = s;
      2'd2:    nv = old | s;
      default: nv = old & ~s;
    endcase
    issue(OP_SYSTEM, ADD, sys_imm(fn, addr, src[4:0]), pc, src, 0, old, pc + 4, 0, 0);
    csr_write(addr, nv);
  endtask

  task automatic end_test(string name, integer err_before);
    n_tests++;
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  initial begin
    logic [31:0] a, b, pc, imm, base, data;
    logic [11:0] addrs [4];
    alu_op_e br_ops [6];
    integer e0;
    seed = 32'h786ce2de;
    errors = 0;
    n_tests = 0;
    n_instr = 0;
    hold_ready = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    opcode_i = '0;
    alu_op_i = ADD;
    imm_i = '0;
    pc_i = '0;
    rs1_val_i = '0;
    rs2_val_i = '0;
    rd_i = '0;
    rd_wen_i = 1'b0;
    exp_wdata = '0;
    exp_npc = '0;
    exp_rd = '0;
    exp_ebreak = 1'b0;
    exp_addr = '0;
    exp_wen = 1'b0;
    exp_we = 1'b0;
    m_mstatus = 0;
    m_mtvec = 32'h100;
    m_mepc = 0;
    m_mcause = 0;
    addrs = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
    br_ops = '{SUB, XOR, SLT, SGE, SLTU, SGEU};
    do @(negedge clk); while (rst);
    @(posedge clk);

    e0 = errors;
    for (int k = 0; k < 13; k++) begin
      repeat (4) begin
        a = $random(seed);
        b = $random(seed);
        pc = $random(seed) & 32'hfffc;
        if (alu_op_e'(k) == PASSB) begin
          issue(OP_LUI, PASSB, b, pc, a, 0, b, pc + 4, 0, 0);
        end else begin
          issue(OP_ALU, alu_op_e'(k), 0, pc, a, b, alu_model(alu_op_e'(k), a, b), pc + 4, 0, 0);
          issue(OP_ALUI, alu_op_e'(k), b, pc, a, 0, alu_model(alu_op_e'(k), a, b), pc + 4, 0, 0);
        end
      end
    end
    issue(OP_AUIPC, ADD, 32'h5000, 32'h40, 0, 0, 32'h5040, 32'h44, 0, 0);
    end_test("alu", e0);

    e0 = errors;
    foreach (br_ops[i]) begin
      repeat (4) begin
        a = $random(seed);
        b = ($random(seed) & 1) ? a : $random(seed);
        pc = $random(seed) & 32'hfffc;
        imm = ($random(seed) & 32'hffc) - 32'h800;
        data = alu_model(br_ops[i], a, b);
        issue(OP_BRANCH, br_ops[i], imm, pc, a, b, data,
              branch_taken(br_ops[i], a, b) ? pc + imm : pc + 4, 0, 0);
      end
    end
    repeat (4) begin
      pc = $random(seed) & 32'hfffc;
      a = $random(seed);
      imm = ($random(seed) & 32'hfff) - 32'h800;
      issue(OP_JAL, ADD, imm, pc, a, 0, pc + 4, (pc + imm) & ~32'h1, 0, 0);
      issue(OP_JALR, ADD, imm, pc, a, 0, pc + 4, (a + imm) & ~32'h1, 0, 0);
    end
    end_test("branch", e0);

    e0 = errors;
    repeat (8) begin
      base = $random(seed) & 32'h3f0;
      imm = $random(seed) & 32'hc;
      data = $random(seed);
      pc = $random(seed) & 32'hfffc;
      issue(OP_STORE, ADD, imm, pc, base, data, base + imm, pc + 4, 0, base + imm);
      issue(OP_LOAD, ADD, imm, pc + 4, base, 0, data, pc + 8, 0, base + imm);
    end
    end_test("memory", e0);

    e0 = errors;
    for (int f = 1; f < 8; f++) begin
      if (f != 4) begin
        foreach (addrs[i]) begin
          csr_op(f, addrs[i], $random(seed), 32'h80);
          csr_op(CSRRS, addrs[i], 0, 32'h84);
        end
      end
    end
    end_test("csr", e0);

    e0 = errors;
    csr_op(CSRRW, CSR_MTVEC, 32'h200, 32'h10);
    csr_op(CSRRW, CSR_MSTATUS, 32'h8, 32'h14); // MIE set, MPIE clear.
    issue(OP_SYSTEM, ADD, sys_imm(PRIV, PRIV_ECALL, 0), 32'h18, 0, 0, 0, m_mtvec, 0, 0);
    m_mepc = 32'h18;
    m_mcause = 11;
    m_mstatus = (m_mstatus & ~32'h88) | ((m_mstatus & 32'h8) << 4);
    csr_op(CSRRS, CSR_MCAUSE, 0, 32'h200);
    csr_op(CSRRS, CSR_MEPC, 0, 32'h204);
    csr_op(CSRRS, CSR_MSTATUS, 0, 32'h208);
    issue(OP_SYSTEM, ADD, sys_imm(PRIV, PRIV_MRET, 0), 32'h20c, 0, 0, 0, m_mepc, 0, 0);
    m_mstatus = (m_mstatus & ~32'h8) | ((m_mstatus >> 4) & 32'h8) | 32'h80;
    csr_op(CSRRS, CSR_MSTATUS, 0, 32'h18);
    issue(OP_SYSTEM, ADD, sys_imm(PRIV, PRIV_EBREAK, 0), 32'h1c, 0, 0, 0, 32'h20, 1, 0);
    end_test("trap", e0);

    e0 = errors;
    hold_ready <= 1'b1;
    @(posedge clk);
    fork
      csr_op(CSRRS, CSR_MCAUSE, 32'h30, 32'h300);
      begin
        repeat (8) @(posedge clk);
        hold_ready <= 1'b0;
      end
    join
    csr_op(CSRRS, CSR_MCAUSE, 0, 32'h304);
    end_test("backpressure", e0);

    $display("%0d tests run, %0d instructions, %0d errors", n_tests, n_instr, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/rv_isa_pkg.sv
hw/exu_mem_pkg.sv
hw/exu_alu.sv
hw/exu_csr_file.sv
hw/exu_lsu_wb.sv
hw/exu_core.sv
hw/exu_top.sv
dv/tb_clk_gen.sv
dv/tb_wb_mem.sv
dv/tb_exu_top.sv

/* Bender.yml */
package:
  name: exu_stage

sources:
  - files:
      - hw/rv_isa_pkg.sv
      - hw/exu_mem_pkg.sv
      - hw/exu_alu.sv
      - hw/exu_csr_file.sv
      - hw/exu_lsu_wb.sv
      - hw/exu_core.sv
      - hw/exu_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_wb_mem.sv
      - dv/tb_exu_top.sv
